// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= htif_bridge_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -qF '*** TEST PASSED ***' $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
+incdir+verilog
verilog/htif_axi_pkg.sv
verilog/htif_stream_pkg.sv
verilog/htif_cmd_if.sv
verilog/htif_fifo.sv
verilog/htif_axi_decode.sv
verilog/htif_host_in.sv
verilog/htif_host_out.sv
verilog/htif_axi_result.sv
verilog/htif_bridge.sv
sim/htif_bridge_props.sv
sim/htif_bridge_tb.sv

// ==== sim/htif_bridge_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module htif_bridge_props (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire logic                         arready,
  input  wire logic                         rvalid,
  input  wire logic                         rready,
  input  wire htif_stream_pkg::host_word_t  rdata,
  input  wire htif_axi_pkg::axi_id_t        rid,
  input  wire logic                         bvalid,
  input  wire logic                         bready,
  input  wire htif_axi_pkg::axi_id_t        bid,
  input  wire logic                         host_in_valid,
  input  wire logic                         host_in_ready,
  input  wire htif_stream_pkg::host_half_t  host_in_bits,
  input  wire logic                         cpu_reset
);

  int fail_count = 0;

  r_hold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid))
  else
  begin
    fail_count++;
    $error("read response changed before rready");
  end

  b_hold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid && $stable(bid))
  else
  begin
    fail_count++;
    $error("write response changed before bready");
  end

  // a stalled half must not move under the target
  in_hold: assert property (@(posedge clk) disable iff (reset)
    host_in_valid && !host_in_ready |=> host_in_valid && $stable(host_in_bits))
  else
  begin
    fail_count++;
    $error("host_in half changed while stalled");
  end

  ar_block: assert property (@(posedge clk) disable iff (reset) !(arready && rvalid))
  else
  begin
    fail_count++;
    $error("arready high during a read response");
  end

  rst_pulse: assert property (@(posedge clk) disable iff (reset) cpu_reset |=> !cpu_reset)
  else
  begin
    fail_count++;
    $error("cpu_reset held for more than one cycle");
  end

  after_rst: assert property (@(posedge clk) $fell(reset) |-> !rvalid && !bvalid && !cpu_reset)
  else
  begin
    fail_count++;
    $error("response or cpu_reset active right after reset");
  end

endmodule

bind htif_bridge htif_bridge_props i_props (.*);

`default_nettype wire

// ==== sim/htif_bridge_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "htif_config.svh"

module htif_bridge_tb;

  // about 200 + 80 + 45 + 775 cycles for the four tests
  localparam int EST_CYCLES = 1100;

  logic                           clk = 1'b0;
  logic                           reset;
  logic                           arvalid, arready, rvalid, rready, rlast;
  logic                           awvalid, awready, wvalid, wready, bvalid, bready;
  htif_axi_pkg::axi_addr_t        araddr, awaddr;
  htif_axi_pkg::axi_id_t          arid, rid, awid, bid;
  htif_stream_pkg::host_word_t    wdata, rdata;
  logic                           host_in_valid, host_out_valid, host_out_ready, cpu_reset;
  logic                           host_in_ready = 1'b0;
  htif_stream_pkg::host_half_t    host_in_bits, host_out_bits;

  int                             seed = 34;
  int                             errors = 0;
  int                             checks = 0;
  int                             pulses = 0;
  int                             writes_done = 0;
  int                             exp_count = 0;
  logic                           drain_en = 1'b0;
  logic                           pending_valid = 1'b0;
  htif_stream_pkg::host_half_t    pending;
  string                          test_name = "reset";
  htif_stream_pkg::host_half_t    exp_halves[$];
  htif_stream_pkg::host_word_t    exp_words[$];

  htif_bridge i_dut (.*);

  always #4 clk = ~clk;

  // target side takes host_in halves on about three cycles out of four
  always @(posedge clk)
    host_in_ready <= drain_en && ($random(seed) % 4 != 0);

  always @(posedge clk)
  begin
    if (!reset && cpu_reset)
      pulses++;
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("mismatch %s/%s: expected %h, actual %h", test_name, name, exp, got);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("error in %s: %s", test_name, msg);
  endtask

  // halves leave in write order with the low half first
  always @(posedge clk)
  begin
    if (!reset && host_in_valid && host_in_ready)
    begin
      if (exp_halves.size() == 0)
        report_error("host_in sent a half that was never written");
      else
        check_value("host_in", 32'(exp_halves.pop_front()), 32'(host_in_bits));
    end
  end

  assert property (@(posedge clk) disable iff (reset) rvalid |-> rlast)
  else
  begin
    errors++;
    $display("rlast was low during a read response");
  end

  task automatic axi_write(input logic [`HTIF_REG_AW-1:0] index,
                           input htif_stream_pkg::host_word_t data);
    htif_axi_pkg::axi_id_t id;
    id = htif_axi_pkg::axi_id_t'($random(seed));
    @(posedge clk);
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    awaddr <= htif_axi_pkg::axi_addr_t'(index) << 2;
    awid <= id;
    wdata <= data;
    do
      @(posedge clk);
    while (!awready);
    check_value("wready", 32'(1), 32'(wready));
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    do
      @(posedge clk);
    while (!bvalid);
    repeat ($random(seed) & 3) @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
    check_value("bid", 32'(id), 32'(bid));
    writes_done++;
  endtask

  task automatic axi_read(input logic [`HTIF_REG_AW-1:0] index,
                          output htif_stream_pkg::host_word_t data);
    htif_axi_pkg::axi_id_t id;
    id = htif_axi_pkg::axi_id_t'($random(seed));
    @(posedge clk);
    arvalid <= 1'b1;
    araddr <= htif_axi_pkg::axi_addr_t'(index) << 2;
    arid <= id;
    do
      @(posedge clk);
    while (!arready);
    arvalid <= 1'b0;
    do
      @(posedge clk);
    while (!rvalid);
    repeat ($random(seed) & 3) @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    data = rdata;
    rready <= 1'b0;
    check_value("rid", 32'(id), 32'(rid));
  endtask

  task automatic read_check(input logic [`HTIF_REG_AW-1:0] index, input logic [31:0] exp,
                            input string name);
    htif_stream_pkg::host_word_t got;
    axi_read(index, got);
    check_value(name, exp, got);
  endtask

  task automatic write_word(input htif_stream_pkg::host_word_t w);
    exp_halves.push_back(w[15:0]);
    exp_halves.push_back(w[31:16]);
    axi_write(`HTIF_WR_FIFO_REG, w);
  endtask

  // first half of each pair lands in the low bits
  task automatic feed_half(input htif_stream_pkg::host_half_t h);
    @(posedge clk);
    host_out_valid <= 1'b1;
    host_out_bits <= h;
    do
      @(posedge clk);
    while (!host_out_ready);
    host_out_valid <= 1'b0;
    if (pending_valid)
    begin
      exp_words.push_back({h, pending});
      exp_count++;
    end
    else
      pending = h;
    pending_valid = !pending_valid;
  endtask

  task automatic pop_word_check();
    read_check(`HTIF_RD_FIFO_REG, exp_words.pop_front(), "host_out word");
    exp_count--;
  endtask

  task automatic wait_host_in_drained();
    while (exp_halves.size() != 0)
      @(posedge clk);
  endtask

  initial
  begin
    reset <= 1'b1;
    arvalid <= 1'b0;
    araddr <= '0;
    arid <= '0;
    rready <= 1'b0;
    awvalid <= 1'b0;
    awaddr <= '0;
    awid <= '0;
    wvalid <= 1'b0;
    wdata <= '0;
    bready <= 1'b0;
    host_out_valid <= 1'b0;
    host_out_bits <= '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    test_name = "host_in order";
    drain_en <= 1'b1;
    for (int i = 0; i < 16; i++)
      write_word(htif_stream_pkg::host_word_t'($random(seed)));
    wait_host_in_drained();

    test_name = "host_out pack";
    for (int i = 0; i < 12; i++)
      feed_half(htif_stream_pkg::host_half_t'($random(seed)));
    read_check(`HTIF_RD_COUNT_REG, 32'(exp_count), "count");
    repeat (6) pop_word_check();
    read_check(`HTIF_RD_COUNT_REG, 32'(0), "count after drain");

    test_name = "cpu reset";
    feed_half(htif_stream_pkg::host_half_t'($random(seed)));
    feed_half(htif_stream_pkg::host_half_t'($random(seed)));
    for (int i = 0; i < 3; i++)
      axi_write(`HTIF_WR_RESET_REG, htif_stream_pkg::host_word_t'($random(seed)));
    check_value("reset pulses", 32'(3), 32'(pulses));
    read_check(`HTIF_RD_COUNT_REG, 32'(exp_count), "count");
    pop_word_check();

    test_name = "back-pressure";
    drain_en <= 1'b0;
    writes_done = 0;
    @(posedge clk);
    fork
      for (int i = 0; i < 34; i++)
        write_word(htif_stream_pkg::host_word_t'($random(seed)));
      begin
        wait (writes_done == 32);
        repeat (20) @(posedge clk);
        assert (writes_done == 32 && awready)
        else
          report_error("write data phase went on with a full host_in queue");
        drain_en <= 1'b1;
      end
    join
    wait_host_in_drained();
    for (int i = 0; i < 64; i++)
      feed_half(htif_stream_pkg::host_half_t'($random(seed)));
    repeat (2) @(posedge clk);
    assert (!host_out_ready)
    else
      report_error("host_out_ready stayed high with a full host_out queue");
    read_check(`HTIF_RD_COUNT_REG, 32'(32), "full count");
    repeat (32) pop_word_check();

    repeat (4) @(posedge clk);
    $display("checks: %0d, errors: %0d, property failures: %0d",
             checks, errors, i_dut.i_props.fail_count);
    if (errors == 0 && i_dut.i_props.fail_count == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    #(EST_CYCLES * 4 * 8);
    $display("timeout: tests still running after %0d ns in %s", EST_CYCLES * 4 * 8, test_name);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/htif_axi_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "htif_config.svh"

module htif_axi_decode (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       arvalid,
  output logic                            arready,
  input  wire htif_axi_pkg::axi_addr_t    araddr,
  input  wire htif_axi_pkg::axi_id_t      arid,
  input  wire logic                       awvalid,
  output logic                            awready,
  input  wire htif_axi_pkg::axi_addr_t    awaddr,
  input  wire htif_axi_pkg::axi_id_t      awid,
  input  wire logic                       wvalid,
  output logic                            wready,
  input  wire logic                       in_full,
  output logic                            in_push,
  output logic                            cpu_reset,
  htif_cmd_if.decode                      cmd
);

  typedef enum logic {RD_IDLE, RD_ISSUE} rd_state_t;
  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_ACK} wr_state_t;

  rd_state_t               rd_state;
  wr_state_t               wr_state;
  logic [`HTIF_REG_AW-1:0] rd_index;
  logic [`HTIF_REG_AW-1:0] wr_index;
  htif_axi_pkg::reg_sel_t  rd_sel_dec;
  htif_axi_pkg::reg_sel_t  wr_sel_dec;
  htif_axi_pkg::reg_sel_t  wr_sel;
  logic                    rd_accept;
  logic                    data_phase;
  logic                    wr_complete;

  assign rd_index = araddr[`HTIF_REG_AW+1:2];
  assign wr_index = awaddr[`HTIF_REG_AW+1:2];

  always_comb
  begin
    case (rd_index)
      `HTIF_RD_COUNT_REG: rd_sel_dec = htif_axi_pkg::REG_COUNT;
      `HTIF_RD_FIFO_REG:  rd_sel_dec = htif_axi_pkg::REG_FIFO;
      default:            rd_sel_dec = htif_axi_pkg::REG_NONE;
    endcase
  end

  always_comb
  begin
    case (wr_index)
      `HTIF_WR_FIFO_REG:  wr_sel_dec = htif_axi_pkg::REG_FIFO;
      `HTIF_WR_RESET_REG: wr_sel_dec = htif_axi_pkg::REG_RESET;
      default:            wr_sel_dec = htif_axi_pkg::REG_NONE;
    endcase
  end

  // one read in flight, the next address waits until the r channel drains
  assign arready = (rd_state == RD_IDLE) && !cmd.rd_busy;
  assign rd_accept = arvalid && arready;
  assign cmd.rd_start = (rd_state == RD_ISSUE);

  always_ff @(posedge clk)
  begin
    if (reset)
      rd_state <= RD_IDLE;
    else
      rd_state <= rd_accept ? RD_ISSUE : RD_IDLE;
  end

  always_ff @(posedge clk)
  begin
    if (rd_accept)
    begin
      cmd.rd_sel <= rd_sel_dec;
      cmd.rd_id <= arid;
    end
  end

  // data phase holds while the host-in queue is full
  assign data_phase = (wr_state == WR_DATA);
  assign wr_complete = data_phase && ((wr_sel != htif_axi_pkg::REG_FIFO) || !in_full);
  assign awready = data_phase;
  assign wready = data_phase;
  assign in_push = data_phase && (wr_sel == htif_axi_pkg::REG_FIFO) && !in_full;
  assign cpu_reset = data_phase && (wr_sel == htif_axi_pkg::REG_RESET);
  assign cmd.wr_done = wr_complete;

  always_ff @(posedge clk)
  begin
    if (reset)
      wr_state <= WR_IDLE;
    else
    begin
      case (wr_state)
        WR_IDLE:
          if (awvalid && wvalid)
            wr_state <= WR_DATA;
        WR_DATA:
          if (wr_complete)
            wr_state <= WR_ACK;
        WR_ACK:
          if (!cmd.wr_busy)
            wr_state <= WR_IDLE;
        default:
          wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((wr_state == WR_IDLE) && awvalid && wvalid)
    begin
      wr_sel <= wr_sel_dec;
      cmd.wr_id <= awid;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/htif_axi_pkg.sv ====
`default_nettype none

`include "htif_config.svh"

package htif_axi_pkg;

  // transaction ID as seen on ar, r, aw and b
  typedef logic [`HTIF_ID_W-1:0] axi_id_t;

  typedef logic [31:0] axi_addr_t;

  // decoded register target of an accepted command
  typedef enum logic [1:0]
  {
    REG_COUNT,
    REG_FIFO,
    REG_RESET,
    REG_NONE
  } reg_sel_t;

endpackage

`default_nettype wire

// ==== verilog/htif_axi_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module htif_axi_result (
  input  wire logic                           clk,
  input  wire logic                           reset,
  output logic                                rvalid,
  input  wire logic                           rready,
  output htif_stream_pkg::host_word_t         rdata,
  output htif_axi_pkg::axi_id_t               rid,
  output logic                                rlast,
  output logic                                bvalid,
  input  wire logic                           bready,
  output htif_axi_pkg::axi_id_t               bid,
  output logic                                out_pop,
  input  wire htif_stream_pkg::host_word_t    out_word,
  input  wire htif_stream_pkg::fifo_count_t   out_count,
  htif_cmd_if.result                          cmd
);

  logic                   rd_busy_q;
  logic                   wr_busy_q;
  htif_axi_pkg::reg_sel_t rd_sel_q;
  logic                   rd_avail;

  assign rvalid = rd_busy_q;
  assign rlast = rd_busy_q;
  assign bvalid = wr_busy_q;
  assign cmd.rd_busy = rd_busy_q;
  assign cmd.wr_busy = wr_busy_q;

  // pop only the word that was captured into rdata
  assign out_pop = rd_busy_q && rready && (rd_sel_q == htif_axi_pkg::REG_FIFO) && rd_avail;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_busy_q <= 1'b0;
      wr_busy_q <= 1'b0;
    end
    else
    begin
      if (cmd.rd_start)
        rd_busy_q <= 1'b1;
      else if (rready)
        rd_busy_q <= 1'b0;
      if (cmd.wr_done)
        wr_busy_q <= 1'b1;
      else if (bready)
        wr_busy_q <= 1'b0;
    end
  end

  // read data is sampled once so it holds while the master stalls
  always_ff @(posedge clk)
  begin
    if (cmd.rd_start)
    begin
      rd_sel_q <= cmd.rd_sel;
      rid <= cmd.rd_id;
      rd_avail <= (out_count != '0);
      if (cmd.rd_sel == htif_axi_pkg::REG_COUNT)
        rdata <= htif_stream_pkg::host_word_t'(out_count);
      else
        rdata <= out_word;
    end
    if (cmd.wr_done)
      bid <= cmd.wr_id;
  end

endmodule

`default_nettype wire

// ==== verilog/htif_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module htif_bridge (
  input  wire logic                         clk,
  input  wire logic                         reset,
  // AXI read address
  input  wire logic                         arvalid,
  output logic                              arready,
  input  wire htif_axi_pkg::axi_addr_t      araddr,
  input  wire htif_axi_pkg::axi_id_t        arid,
  // AXI read data
  output logic                              rvalid,
  input  wire logic                         rready,
  output htif_stream_pkg::host_word_t       rdata,
  output htif_axi_pkg::axi_id_t             rid,
  output logic                              rlast,
  // AXI write address and data
  input  wire logic                         awvalid,
  output logic                              awready,
  input  wire htif_axi_pkg::axi_addr_t      awaddr,
  input  wire htif_axi_pkg::axi_id_t        awid,
  input  wire logic                         wvalid,
  output logic                              wready,
  input  wire htif_stream_pkg::host_word_t  wdata,
  // AXI write response, always OKAY
  output logic                              bvalid,
  input  wire logic                         bready,
  output htif_axi_pkg::axi_id_t             bid,
  // target streams
  output logic                              host_in_valid,
  input  wire logic                         host_in_ready,
  output htif_stream_pkg::host_half_t       host_in_bits,
  input  wire logic                         host_out_valid,
  output logic                              host_out_ready,
  input  wire htif_stream_pkg::host_half_t  host_out_bits,
  output logic                              cpu_reset
);

  logic                         in_push;
  logic                         in_full;
  logic                         out_pop;
  htif_stream_pkg::host_word_t  out_word;
  htif_stream_pkg::fifo_count_t out_count;

  htif_cmd_if cmd_bus ();

  htif_axi_decode i_decode (
    .clk       (clk),
    .reset     (reset),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .arid      (arid),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .awid      (awid),
    .wvalid    (wvalid),
    .wready    (wready),
    .in_full   (in_full),
    .in_push   (in_push),
    .cpu_reset (cpu_reset),
    .cmd       (cmd_bus.decode)
  );

  // wdata is held by the master for the whole data phase
  htif_host_in i_host_in (
    .clk           (clk),
    .reset         (reset),
    .push          (in_push),
    .word          (wdata),
    .full          (in_full),
    .host_in_valid (host_in_valid),
    .host_in_ready (host_in_ready),
    .host_in_bits  (host_in_bits)
  );

  htif_host_out i_host_out (
    .clk            (clk),
    .reset          (reset),
    .host_out_valid (host_out_valid),
    .host_out_ready (host_out_ready),
    .host_out_bits  (host_out_bits),
    .pop            (out_pop),
    .word           (out_word),
    .count          (out_count)
  );

  htif_axi_result i_result (
    .clk       (clk),
    .reset     (reset),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .rid       (rid),
    .rlast     (rlast),
    .bvalid    (bvalid),
    .bready    (bready),
    .bid       (bid),
    .out_pop   (out_pop),
    .out_word  (out_word),
    .out_count (out_count),
    .cmd       (cmd_bus.result)
  );

endmodule

`default_nettype wire

// ==== verilog/htif_cmd_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface htif_cmd_if;

  // read command, rd_sel and rd_id are valid while rd_start is high
  logic                   rd_start;
  htif_axi_pkg::reg_sel_t rd_sel;
  htif_axi_pkg::axi_id_t  rd_id;

  // write completion, one cycle wide
  logic                   wr_done;
  htif_axi_pkg::axi_id_t  wr_id;

  // response channels still owned by the master
  logic                   rd_busy;
  logic                   wr_busy;

  modport decode (
    output rd_start,
    output rd_sel,
    output rd_id,
    output wr_done,
    output wr_id,
    input  rd_busy,
    input  wr_busy
  );

  modport result (
    input  rd_start,
    input  rd_sel,
    input  rd_id,
    input  wr_done,
    input  wr_id,
    output rd_busy,
    output wr_busy
  );

endinterface

`default_nettype wire

// ==== verilog/htif_config.svh ====
`ifndef HTIF_CONFIG_SVH
`define HTIF_CONFIG_SVH

// AXI transaction ID width on the ARM side
`define HTIF_ID_W 12

// register index taken from address bits 6 down to 2
`define HTIF_REG_AW 5

// read register map
`define HTIF_RD_COUNT_REG 5'd0
`define HTIF_RD_FIFO_REG 5'd1

// write register map
`define HTIF_WR_FIFO_REG 5'd0
`define HTIF_WR_RESET_REG 5'd31

// words per stream queue
`define HTIF_FIFO_DEPTH 32

`endif

// ==== verilog/htif_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module htif_fifo #(
  parameter int DEPTH = 32
) (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire logic                         push,
  input  wire logic                         pop,
  input  wire htif_stream_pkg::host_word_t  din,
  output htif_stream_pkg::host_word_t       dout,
  output logic                              full,
  output logic                              empty,
  output htif_stream_pkg::fifo_count_t      count
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);
  localparam htif_stream_pkg::fifo_count_t FULL_COUNT =
    htif_stream_pkg::fifo_count_t'(DEPTH);

  htif_stream_pkg::host_word_t  mem [DEPTH];
  logic [AW-1:0]                wr_ptr;
  logic [AW-1:0]                rd_ptr;
  logic                         do_write;
  logic                         do_read;
  htif_stream_pkg::fifo_count_t count_next;

  // a full queue still takes a push when a pop frees a slot in the same cycle
  assign do_write = push && (!full || pop);
  assign do_read = pop && !empty;

  assign count_next = count
                    + htif_stream_pkg::fifo_count_t'(do_write)
                    - htif_stream_pkg::fifo_count_t'(do_read);

  // show-ahead read port
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_write)
      mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      empty <= 1'b1;
      full <= 1'b0;
    end
    else
    begin
      if (do_write)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (do_read)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      count <= count_next;
      empty <= (count_next == '0);
      full <= (count_next == FULL_COUNT);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/htif_host_in.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "htif_config.svh"

module htif_host_in (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire logic                         push,
  input  wire htif_stream_pkg::host_word_t  word,
  output logic                              full,
  output logic                              host_in_valid,
  input  wire logic                         host_in_ready,
  output htif_stream_pkg::host_half_t       host_in_bits
);

  htif_stream_pkg::host_word_t head;
  logic                        empty;
  logic                        hi_sel;
  logic                        take;

  htif_fifo #(
    .DEPTH (`HTIF_FIFO_DEPTH)
  ) i_fifo (
    .clk   (clk),
    .reset (reset),
    .push  (push),
    .pop   (take && hi_sel),
    .din   (word),
    .dout  (head),
    .full  (full),
    .empty (empty),
    .count ()
  );

  assign host_in_valid = !empty;
  assign take = host_in_valid && host_in_ready;

  // low half goes out first, the word leaves the queue with its high half
  assign host_in_bits = hi_sel ? head[31:16] : head[15:0];

  always_ff @(posedge clk)
  begin
    if (reset)
      hi_sel <= 1'b0;
    else if (take)
      hi_sel <= !hi_sel;
  end

endmodule

`default_nettype wire

// ==== verilog/htif_host_out.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "htif_config.svh"

module htif_host_out (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire logic                         host_out_valid,
  output logic                              host_out_ready,
  input  wire htif_stream_pkg::host_half_t  host_out_bits,
  input  wire logic                         pop,
  output htif_stream_pkg::host_word_t       word,
  output htif_stream_pkg::fifo_count_t      count
);

  htif_stream_pkg::host_half_t first_half;
  logic                        full;
  logic                        hi_sel;
  logic                        take;

  // no push can land between the two halves, so ready only needs the full flag
  assign host_out_ready = !full;
  assign take = host_out_valid && host_out_ready;

  htif_fifo #(
    .DEPTH (`HTIF_FIFO_DEPTH)
  ) i_fifo (
    .clk   (clk),
    .reset (reset),
    .push  (take && hi_sel),
    .pop   (pop),
    .din   ({host_out_bits, first_half}),
    .dout  (word),
    .full  (full),
    .empty (),
    .count (count)
  );

  always_ff @(posedge clk)
  begin
    if (reset)
      hi_sel <= 1'b0;
    else if (take)
      hi_sel <= !hi_sel;
  end

  // first half of a pair ends up in the low bits
  always_ff @(posedge clk)
  begin
    if (take && !hi_sel)
      first_half <= host_out_bits;
  end

endmodule

`default_nettype wire

// ==== verilog/htif_stream_pkg.sv ====
`default_nettype none

`include "htif_config.svh"

package htif_stream_pkg;

  // one queue entry, as written or read by the ARM
  typedef logic [31:0] host_word_t;

  // one beat on the target-side host streams
  typedef logic [15:0] host_half_t;

  // one bit wider than the pointers so a full queue reads as its depth
  typedef logic [$clog2(`HTIF_FIFO_DEPTH + 1)-1:0] fifo_count_t;

endpackage

`default_nettype wire
